// ==== dv/final_norm_input.txt ====
// columns: sum (19-bit), sign, mantissa (11-bit), exponent adjustment (5-bit signed), carry
// all values hex, one sum per line
20000 0 400 04 0
10000 0 400 03 0
08000 0 400 02 0
04000 0 400 01 0
02abc 0 558 00 0
01000 0 400 1f 0
00800 0 400 1e 0
00400 0 400 1d 0
003ff 0 7fe 1c 0
00100 0 400 1b 0
00080 0 400 1a 0
00040 0 400 19 0
0002b 0 560 18 0
00010 0 400 17 0
00008 0 400 16 0
20041 0 401 04 0 // grs 011 rounds up
200c0 0 402 04 0 // grs 110 rounds up
200c1 0 402 04 0 // grs 111 rounds up
20040 0 400 04 0 // grs 010 tie, already even
20081 0 401 04 0 // grs 101
20080 0 401 04 0 // grs 100
20001 0 400 04 0 // grs 001
3ffc0 0 400 04 1 // all ones window carries out
01ffe 0 400 1f 1
7d544 1 558 00 0
5ffbf 1 401 04 0
40040 1 400 04 1
7fff8 1 400 16 0
7ffff 1 000 00 0 // magnitude 1, below bit 3
00000 0 000 00 0
00007 0 000 00 0
40000 1 000 00 0 // top bit only, magnitude folds to zero

// ==== dv/tb_final_norm.sv ====
`timescale 1ns/1ps

module tb_final_norm import fp_norm_pkg::*; ();

    localparam int CREDITS   = 4;
    // vector file columns: sum, sign, mantissa, adjustment, carry
    localparam int COLS      = 5;
    localparam int MAX_VEC   = 64;
    // back-to-back inputs at the start so the credits run out
    localparam int BURST_LEN = 8;

    logic     i_clk = 1'b0;
    logic     i_reset;
    logic     i_valid;
    sum_t     i_sum;
    logic     i_credit;
    logic     o_ready;
    logic     o_valid;
    logic     o_sign;
    mant_t    o_mant;
    exp_adj_t o_exp_adj;
    logic     o_exp_carry;

    sum_t vec_mem [0:COLS*MAX_VEC-1];
    int   n_vec;
    int   cycle_cnt = 0;
    int   cycle_limit;

    // scoreboard, vector index and expected result cycle per accepted input
    int   acc_idx_q[$];
    int   due_cyc_q[$];
    // cycles at which the model consumer frees a slot
    int   credit_due_q[$];

    int   drv_idx;
    logic will_accept;
    logic saw_not_ready = 1'b0;
    int   acc_cnt = 0;
    int   ret_cnt = 0;
    int   res_cnt = 0;
    int   value_err = 0;
    int   proto_err = 0;
    int   end_err = 0;

    final_norm_top #(.CREDITS(CREDITS)) dut (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_valid     (i_valid),
        .i_sum       (i_sum),
        .o_ready     (o_ready),
        .o_valid     (o_valid),
        .o_sign      (o_sign),
        .o_mant      (o_mant),
        .o_exp_adj   (o_exp_adj),
        .o_exp_carry (o_exp_carry),
        .i_credit    (i_credit)
    );

    // 8 ns clock
    always #4 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic check_bit(input string name, input logic exp_val, input logic act_val);
        if (act_val !== exp_val) begin
            $display("Error at %0d ns: %s expected %b got %b", $time, name, exp_val, act_val);
            value_err++;
        end
    endtask

    task automatic check_mant(input string name, input mant_t exp_val, input mant_t act_val);
        if (act_val !== exp_val) begin
            $display("Error at %0d ns: %s expected %h got %h", $time, name, exp_val, act_val);
            value_err++;
        end
    endtask

    task automatic check_exp(input string name, input exp_adj_t exp_val,
                             input exp_adj_t act_val);
        if (act_val !== exp_val) begin
            $display("Error at %0d ns: %s expected %0d got %0d", $time, name, exp_val, act_val);
            value_err++;
        end
    endtask

    // results the consumer still holds may never exceed its buffer
    task automatic check_credit_limit(input int outstanding);
        if (outstanding > CREDITS) begin
            $display("Error at %0d ns: outstanding results expected at most %0d got %0d",
                     $time, CREDITS, outstanding);
            value_err++;
        end
    endtask

    // address-dependent fill keeps the sign column out of range where no line was read
    task automatic load_vectors();
        int base;
        logic ok;
        for (int a = 0; a < COLS * MAX_VEC; a++) begin
            vec_mem[a] = SUM_W'(32'h40000 | a);
        end
        $readmemh("dv/final_norm_input.txt", vec_mem);
        n_vec = 0;
        ok = 1'b1;
        while (ok && n_vec < MAX_VEC) begin
            base = COLS * n_vec;
            ok = (vec_mem[base+1] <= 19'h1) && (vec_mem[base+2] <= 19'h7ff) &&
                 (vec_mem[base+3] <= 19'h1f) && (vec_mem[base+4] <= 19'h1);
            if (ok) begin
                n_vec++;
            end
        end
        if (n_vec == 0) begin
            $display("no usable vectors found in dv/final_norm_input.txt");
            end_err++;
        end
    endtask

    // present each sum and hold it until the handshake goes through
    task automatic drive_vectors();
        int gap;
        for (int v = 0; v < n_vec; v++) begin
            gap = (v < BURST_LEN) ? 0 : int'($urandom_range(0, 2));
            repeat (gap) begin
                i_valid <= 1'b0;
                @(posedge i_clk);
            end
            i_valid <= 1'b1;
            i_sum   <= vec_mem[COLS*v];
            drv_idx = v;
            @(posedge i_clk);
            while (!will_accept) begin
                @(posedge i_clk);
            end
        end
        i_valid <= 1'b0;
    endtask

    // one o_valid pulse, compared with the oldest accepted vector
    task automatic check_result();
        int idx;
        int due;
        if (acc_idx_q.size() == 0) begin
            $display("o_valid at %0d ns with no input waiting for a result", $time);
            proto_err++;
        end else begin
            idx = acc_idx_q.pop_front();
            due = due_cyc_q.pop_front();
            if (cycle_cnt != due) begin
                $display("result for vector %0d came in cycle %0d, two cycles after accept is %0d",
                         idx, cycle_cnt, due);
                proto_err++;
            end
            check_bit("o_sign", vec_mem[COLS*idx+1][0], o_sign);
            check_mant("o_mant", mant_t'(vec_mem[COLS*idx+2]), o_mant);
            check_exp("o_exp_adj", exp_adj_t'(vec_mem[COLS*idx+3]), o_exp_adj);
            check_bit("o_exp_carry", vec_mem[COLS*idx+4][0], o_exp_carry);
            res_cnt++;
            // slot freed 0 to 3 cycles later
            credit_due_q.push_back(cycle_cnt + 1 + int'($urandom_range(0, 3)));
        end
    endtask

    // falling edge, everything from the last rising edge has settled
    task automatic sample_cycle();
        if (i_reset) begin
            will_accept = 1'b0;
        end else begin
            // model count: ready while fewer than CREDITS are held downstream
            check_bit("o_ready", (acc_cnt - ret_cnt) < CREDITS, o_ready);
            if (!o_ready) begin
                saw_not_ready = 1'b1;
            end
            if (i_credit) begin
                ret_cnt++;
            end
            will_accept = i_valid & o_ready;
            if (will_accept) begin
                acc_idx_q.push_back(drv_idx);
                due_cyc_q.push_back(cycle_cnt + 2);
                acc_cnt++;
            end
            check_credit_limit(acc_cnt - ret_cnt);
            if (o_valid) begin
                check_result();
            end
        end
    endtask

    // at most one credit pulse per cycle
    task automatic return_credit();
        if (!i_reset && credit_due_q.size() != 0 && credit_due_q[0] <= cycle_cnt) begin
            i_credit <= 1'b1;
            void'(credit_due_q.pop_front());
        end else begin
            i_credit <= 1'b0;
        end
    endtask

    // model downstream consumer and output monitor
    initial begin : consumer
        i_credit = 1'b0;
        forever begin
            @(negedge i_clk);
            sample_cycle();
            @(posedge i_clk);
            return_credit();
        end
    end

    initial begin : watchdog
        @(posedge i_clk);
        while (cycle_cnt < cycle_limit) begin
            @(posedge i_clk);
        end
        $display("timeout at cycle %0d, %0d of %0d results, errors: %0d wrong values, %0d protocol",
                 cycle_cnt, res_cnt, n_vec, value_err, proto_err);
        $display("Test FAILED");
        $finish;
    end

    initial begin : main
        int total_err;
        void'($urandom(91));
        i_reset = 1'b1;
        i_valid = 1'b0;
        i_sum   = '0;
        load_vectors();
        cycle_limit = 40 * n_vec + 200;
        repeat (8) @(posedge i_clk);
        i_reset <= 1'b0;
        drive_vectors();
        // wait for every result and every credit to come back
        while (res_cnt < n_vec || credit_due_q.size() != 0 || i_credit) begin
            @(posedge i_clk);
        end
        // idle stretch catches stray o_valid pulses
        repeat (4) @(posedge i_clk);
        @(negedge i_clk);
        if (o_ready !== 1'b1) begin
            $display("o_ready is low after all credits came back");
            end_err++;
        end
        if (acc_cnt != n_vec) begin
            $display("%0d inputs accepted for %0d vectors", acc_cnt, n_vec);
            end_err++;
        end
        if (!saw_not_ready) begin
            $display("o_ready never dropped while the credits were used up");
            end_err++;
        end
        total_err = value_err + proto_err + end_err;
        $display("errors: %0d wrong values, %0d protocol, %0d end of run, %0d vectors",
                 value_err, proto_err, end_err, n_vec);
        if (total_err == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== hw/final_norm_top.sv ====
`timescale 1ns/1ps

module final_norm_top import fp_norm_pkg::*; #(
    // slots in the downstream buffer
    parameter int CREDITS = 4
) (
    input  logic     i_clk,
    input  logic     i_reset,

    // upstream side
    input  logic     i_valid,
    input  sum_t     i_sum,
    output logic     o_ready,

    // downstream side
    output logic     o_valid,
    output logic     o_sign,
    output mant_t    o_mant,
    output exp_adj_t o_exp_adj,
    output logic     o_exp_carry,
    input  logic     i_credit
);

    // wide enough to hold the full credit count
    localparam int CNT_W = $clog2(CREDITS + 1);

    logic [CNT_W-1:0] credit_cnt;
    logic             accept;

    // link between the two pipeline stages
    lead_stage_if u_lead_if ();

    // ready while at least one downstream slot is free
    assign o_ready = (credit_cnt != '0);

    // handshake on the input side
    assign accept = i_valid & o_ready;

    // each accept spends a credit and each returned pulse gives one back
    // both in the same cycle leave the count unchanged
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            credit_cnt <= CNT_W'(CREDITS);
        end else begin
            case ({accept, i_credit})
                2'b10: credit_cnt <= credit_cnt - CNT_W'(1);
                2'b01: credit_cnt <= credit_cnt + CNT_W'(1);
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // sign, magnitude and leading one detection
    leading_one_stage u_leading_one_stage (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_accept (accept),
        .i_sum    (i_sum),
        .o_lead   (u_lead_if.producer)
    );

    // normalize, exponent adjust and round
    // results appear two cycles after the accept edge
    round_stage u_round_stage (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_lead      (u_lead_if.consumer),
        .o_valid     (o_valid),
        .o_sign      (o_sign),
        .o_exp_carry (o_exp_carry),
        .o_mant      (o_mant),
        .o_exp_adj   (o_exp_adj)
    );

endmodule

// ==== hw/fp_norm_pkg.sv ====
package fp_norm_pkg;

    // raw significand sum from the adder, two's complement
    localparam int SUM_W = 19;
    typedef logic [SUM_W-1:0] sum_t;

    // magnitude after taking the sign off
    // the sum with only the top bit set does not fit here and reads as zero
    localparam int MAG_W = 18;
    typedef logic [MAG_W-1:0] mag_t;

    // leading-one detector covers magnitude bits 17 down to 3
    localparam int LEAD_W = 15;
    typedef logic [LEAD_W-1:0] lead_t;

    // magnitude bit that lead index 0 stands for
    localparam int LEAD_LSB = 3;

    // normalized significand, leading one in the top bit
    localparam int MANT_W = 11;
    typedef logic [MANT_W-1:0] mant_t;

    // rounded significand with room for the rounding carry
    localparam int RND_W = MANT_W + 1;
    typedef logic [RND_W-1:0] rnd_t;

    // signed exponent adjustment, -10 up to +4
    localparam int EXP_W = 5;
    typedef logic signed [EXP_W-1:0] exp_adj_t;

    // leading one at this magnitude bit means no exponent change
    localparam int NO_SHIFT_POS = 13;

    // round bit position once the leading one sits in the top magnitude bit
    // guard is the bit just above, sticky covers all the bits below
    localparam int ROUND_POS = MAG_W - 1 - MANT_W;

endpackage

// ==== hw/lead_stage_if.sv ====
`timescale 1ns/1ps

// stage one results handed to the rounding stage
// no handshake here, the pipeline never stalls internally
interface lead_stage_if import fp_norm_pkg::*; ();

    // one cycle strobe per accepted sum
    logic  valid;
    // sign of the original sum
    logic  sign;
    // unsigned magnitude, bits 17..0
    mag_t  mag;
    // one-hot leading position, index k is magnitude bit k+3
    lead_t lead;

    // driven by leading_one_stage
    modport producer (
        output valid,
        output sign,
        output mag,
        output lead
    );

    // read by round_stage
    modport consumer (
        input valid,
        input sign,
        input mag,
        input lead
    );

endinterface

// ==== hw/leading_one_stage.sv ====
`timescale 1ns/1ps

module leading_one_stage import fp_norm_pkg::*; (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_accept,
    input  sum_t                  i_sum,
    lead_stage_if.producer        o_lead
);

    logic  sign;
    mag_t  mag;
    lead_t lead;

    // prefix ORs over groups of magnitude bits, shared by the positions below
    logic or_17_14;
    logic or_17_11;
    logic or_17_8;
    logic or_17_5;

    // sign straight from the top bit of the sum
    assign sign = i_sum[SUM_W-1];

    // invert and increment for negative sums
    // only the low bits are kept so the single top-bit sum folds to zero
    assign mag = sign ? (~i_sum[MAG_W-1:0] + mag_t'(1)) : i_sum[MAG_W-1:0];

    // group prefixes, each one extends the previous by three bits
    assign or_17_14 = |mag[17:14];
    assign or_17_11 = or_17_14 | (|mag[13:11]);
    assign or_17_8  = or_17_11 | (|mag[10:8]);
    assign or_17_5  = or_17_8  | (|mag[7:5]);

    // one-hot leading vector
    // a position is set only when its bit is one and every higher bit is zero

    // first group, no prefix above it
    assign lead[14] = mag[17];
    assign lead[13] = mag[16] & ~mag[17];
    assign lead[12] = mag[15] & ~(|mag[17:16]);
    assign lead[11] = mag[14] & ~(|mag[17:15]);

    // bits 13..11 behind the first group prefix
    assign lead[10] = mag[13] & ~or_17_14;
    assign lead[9]  = mag[12] & ~(or_17_14 | mag[13]);
    assign lead[8]  = mag[11] & ~(or_17_14 | (|mag[13:12]));

    // bits 10..8
    assign lead[7]  = mag[10] & ~or_17_11;
    assign lead[6]  = mag[9]  & ~(or_17_11 | mag[10]);
    assign lead[5]  = mag[8]  & ~(or_17_11 | (|mag[10:9]));

    // bits 7..5
    assign lead[4]  = mag[7]  & ~or_17_8;
    assign lead[3]  = mag[6]  & ~(or_17_8 | mag[7]);
    assign lead[2]  = mag[5]  & ~(or_17_8 | (|mag[7:6]));

    // bits 4..3, anything lower is not detected
    assign lead[1]  = mag[4]  & ~or_17_5;
    assign lead[0]  = mag[3]  & ~(or_17_5 | mag[4]);

    // valid follows the accept strobe one cycle later
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_lead.valid <= 1'b0;
        end else begin
            o_lead.valid <= i_accept;
        end
    end

    // payload loads every cycle
    // only meaningful alongside valid
    always_ff @(posedge i_clk) begin
        o_lead.sign <= sign;
        o_lead.mag  <= mag;
        o_lead.lead <= lead;
    end

endmodule

// ==== hw/round_stage.sv ====
`timescale 1ns/1ps

module round_stage import fp_norm_pkg::*; (
    input  logic                  i_clk,
    input  logic                  i_reset,
    lead_stage_if.consumer        i_lead,
    output logic                  o_valid,
    output logic                  o_sign,
    output logic                  o_exp_carry,
    output mant_t                 o_mant,
    output exp_adj_t              o_exp_adj
);

    // index into the one-hot vector, 0..14
    localparam int IDX_W = $clog2(LEAD_W);

    logic [IDX_W-1:0] lead_idx;
    logic             found;

    // magnitude shifted so the leading one lands in the top bit
    mag_t             aligned;
    mant_t            window;
    exp_adj_t         exp_adj;

    logic             guard_bit;
    logic             round_bit;
    logic             sticky_bit;
    logic             round_up;

    rnd_t             rnd;
    logic             exp_carry;
    mant_t            mant;

    // encode the one-hot vector as an AND-OR over all positions
    always_comb begin
        lead_idx = '0;
        for (int k = 0; k < LEAD_W; k++) begin
            if (i_lead.lead[k]) begin
                lead_idx = lead_idx | IDX_W'(k);
            end
        end
    end

    // nothing detected when the leading one is below bit 3
    assign found = |i_lead.lead;

    // left shift by the distance from the top detectable position
    // zeros fill in below bit 0
    always_comb begin
        if (found) begin
            aligned = i_lead.mag << ((LEAD_W - 1) - int'(lead_idx));
        end else begin
            aligned = '0;
        end
    end

    // 11-bit window starting at the leading one
    assign window = aligned[MAG_W-1 -: MANT_W];

    // position minus 13, zero when no bit was found
    always_comb begin
        if (found) begin
            exp_adj = exp_adj_t'(int'(lead_idx) + LEAD_LSB - NO_SHIFT_POS);
        end else begin
            exp_adj = '0;
        end
    end

    // guard is the lsb of the window itself
    assign guard_bit  = window[0];
    // round is 11 bits below the leading one, zero if shifted in
    assign round_bit  = aligned[ROUND_POS];
    // OR of everything under the round bit
    assign sticky_bit = |aligned[ROUND_POS-1:0];

    // nearest even on G/R/S
    // patterns 011, 110 and 111 go up, the rest truncate
    assign round_up = round_bit & (guard_bit | sticky_bit);

    // extra top bit catches the carry out of an all-ones window
    assign rnd = {1'b0, window} + rnd_t'(round_up);

    assign exp_carry = rnd[RND_W-1];

    // on a carry shift right once so the leading one is back in bit 10
    always_comb begin
        if (exp_carry) begin
            mant = rnd[RND_W-1:1];
        end else begin
            mant = rnd[MANT_W-1:0];
        end
    end

    // output valid, cleared by reset
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_lead.valid;
        end
    end

    // result fields load every cycle
    always_ff @(posedge i_clk) begin
        o_sign      <= i_lead.sign;
        o_mant      <= mant;
        o_exp_adj   <= exp_adj;
        o_exp_carry <= exp_carry;
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module tb_final_norm \
    -f sources.f -o sim_final_norm

./obj_dir/sim_final_norm | tee sim.log

if grep -q "^Test OK$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// ==== sources.f ====
hw/fp_norm_pkg.sv
hw/lead_stage_if.sv
hw/leading_one_stage.sv
hw/round_stage.sv
hw/final_norm_top.sv
dv/tb_final_norm.sv
